/* risc_core.f */
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/insn_decode.sv
verilog/exec_unit.sv
verilog/core_control.sv
verilog/risc_core.sv
test/risc_core_assertions.sv
test/risc_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the risc_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f risc_core.f --top-module risc_core_tb -o risc_core_sim

./obj_dir/risc_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    exit 1
fi

/* test/risc_core_tb.sv */
`default_nettype none

module risc_core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int   CREDITS     = 2;
    localparam int   ROM_DEPTH   = 256;
    localparam int   CYCLE_LIMIT = 5 * 400;   // Five tests, 400 cycles each
    localparam logic [31:0] SEED = 32'ha4c9;

    logic     clk;
    logic     reset_n;
    word_t    o_insn_addr;
    word_t    i_insn_data;
    logic     o_req_valid;
    mem_req_t o_req;
    logic     i_credit_return;
    logic     i_rsp_valid;
    word_t    i_rsp_data;
    logic     o_halt;

    word_t       rom [0:ROM_DEPTH-1];
    word_t       mem [word_t];       // Data memory, sparse
    mem_req_t    store_log [$];
    word_t       pend_addr [$];      // Loads waiting for their response
    int          pend_wait [$];
    int          owed;               // Credits not yet handed back
    int          outstanding;
    int          reset_left;
    int          cycles;
    logic        withhold;
    logic [31:0] lfsr;

    risc_core #(.RESET_VECTOR('0), .MEM_CREDITS(CREDITS)) dut (
        .clk (clk), .reset_n (reset_n), .o_insn_addr (o_insn_addr),
        .i_insn_data (i_insn_data), .o_req_valid (o_req_valid), .o_req (o_req),
        .i_credit_return (i_credit_return), .i_rsp_valid (i_rsp_valid),
        .i_rsp_data (i_rsp_data), .o_halt (o_halt)
    );

    bind core_control risc_core_assertions #(.MEM_CREDITS(MEM_CREDITS), .CREDIT_W(CREDIT_W))
        u_assert (.clk(clk), .reset_n(reset_n), .o_req_valid(o_req_valid),
                  .i_credit_return(i_credit_return), .o_halt(o_halt),
                  .credits(credits_q));

    assign i_insn_data = rom[o_insn_addr[7:0]];   // Asynchronous fetch

    always #5 clk = ~clk;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
            fail_run("Value mismatch");
        end
    endtask

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t enc(logic t, deref_t d, reg_idx_t z, reg_idx_t x,
                                  reg_idx_t y, alu_op_t op, imm_t imm);
        return {1'b0, t, d, z, x, y, op, imm};
    endfunction

    // Load immediate: (R0 | I) + R0
    function automatic word_t li(reg_idx_t z, imm_t imm);
        return enc(1'b1, 2'b00, z, 4'd0, 4'd0, OP_OR, imm);
    endfunction

    function automatic word_t sext(imm_t imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t alu_ref(alu_op_t op, word_t x, word_t o);
        case (op)
            4'd0:    return x | o;
            4'd1:    return x & o;
            4'd2:    return x + o;
            4'd3:    return x * o;
            4'd5:    return (o < 32) ? (x << o) : '0;
            4'd6:    return ($signed(x) <= $signed(o)) ? 32'd1 : 32'd0;
            4'd7:    return (x == o) ? 32'd1 : 32'd0;
            4'd8:    return ~(x | o);
            4'd9:    return ~(x & o);
            4'd10:   return x ^ o;
            4'd11:   return x - o;
            4'd12:   return x ^ ~o;
            4'd13:   return (o < 32) ? (x >> o) : '0;
            4'd14:   return ($signed(x) > $signed(o)) ? 32'd1 : 32'd0;
            4'd15:   return (x != o) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic word_t expect_result(logic t, alu_op_t op, word_t x, word_t y, imm_t imm);
        return t ? alu_ref(op, x, sext(imm)) + y : alu_ref(op, x, y) + sext(imm);
    endfunction

    // Unused words are illegal, so stray fetches halt
    task automatic clear_rom();
        for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[a] = 32'h8000_0000 | word_t'(a);
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        reset_left = 4;
        @(posedge clk);
        while (!reset_n) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_stores(int n);
        while (store_log.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic check_store(int k, word_t addr, word_t data);
        check($sformatf("store[%0d].addr", k), addr, store_log[k].addr);
        check($sformatf("store[%0d].data", k), data, store_log[k].data);
    endtask

    // Reset sequencing and the data memory share one process
    always @(negedge clk) begin
        i_rsp_valid = 1'b0;
        i_credit_return = 1'b0;
        if (reset_left > 0) begin
            reset_n = 1'b0;
            reset_left--;
        end else begin
            reset_n = 1'b1;
        end
        if (!reset_n) begin
            pend_addr.delete();
            pend_wait.delete();
            store_log.delete();
            owed = 0;
            outstanding = 0;
        end else begin
            if (pend_wait.size() > 0) begin
                if (pend_wait[0] == 0) begin
                    i_rsp_valid = 1'b1;
                    i_rsp_data = mem.exists(pend_addr[0]) ? mem[pend_addr[0]] : '0;
                    void'(pend_addr.pop_front());
                    void'(pend_wait.pop_front());
                    owed++;
                end else begin
                    pend_wait[0]--;
                end
            end
            if (owed > 0 && !withhold) begin
                i_credit_return = 1'b1;
                owed--;
                outstanding--;
            end
            if (o_req_valid) begin
                outstanding++;
                if (outstanding > CREDITS) begin
                    fail_run("More requests outstanding than the memory has credits");
                end
                if (o_req.write) begin
                    mem[o_req.addr] = o_req.data;
                    store_log.push_back(o_req);
                    owed++;
                end else begin
                    pend_addr.push_back(o_req.addr);
                    pend_wait.push_back(int'(rand_bits(2)));   // 1 to 4 cycles
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            fail_run("Timeout: the tests ran past the cycle limit");
        end
    end

    task automatic sweep_alu_ops();
        imm_t     ia;
        imm_t     iy [2];
        imm_t     ic;
        reg_idx_t y_reg;
        int       pc;
        int       n;
        word_t    expected [$];
        clear_rom();
        ia = imm_t'(rand_bits(12));
        iy[0] = imm_t'(rand_bits(5));        // Shift amounts below 32
        iy[1] = imm_t'(32 + rand_bits(5));   // Shift amounts of 32 and up
        rom[0] = li(4'd1, ia);
        rom[1] = li(4'd2, iy[0]);
        rom[2] = li(4'd4, iy[1]);
        pc = 3;
        for (int pass = 0; pass < 2; pass++) begin
            y_reg = (pass == 0) ? 4'd2 : 4'd4;
            for (int op = 0; op < 16; op++) begin
                if (op != 4) begin
                    ic = imm_t'(rand_bits(12));
                    rom[pc] = li(4'd3, imm_t'(32 + 16 * pass + op));
                    rom[pc + 1] = enc(1'b0, 2'b10, 4'd3, 4'd1, y_reg, alu_op_t'(op), ic);
                    expected.push_back(expect_result(1'b0, alu_op_t'(op), sext(ia),
                                                     sext(iy[pass]), ic));
                    pc += 2;
                end
            end
        end
        reset_core();
        wait_stores(30);
        n = 0;
        for (int pass = 0; pass < 2; pass++) begin
            for (int op = 0; op < 16; op++) begin
                if (op != 4) begin
                    check_store(n, word_t'(32 + 16 * pass + op), expected[n]);
                    n++;
                end
            end
        end
    endtask

    task automatic swap_operand_types();
        imm_t ia;
        imm_t ib;
        imm_t ic;
        clear_rom();
        ia = imm_t'(rand_bits(12));
        ib = imm_t'(rand_bits(12));
        ic = imm_t'(rand_bits(12));
        rom[0] = li(4'd1, ia);
        rom[1] = li(4'd2, ib);
        rom[2] = enc(1'b0, 2'b10, 4'd0, 4'd1, 4'd2, OP_SUB, ic);
        rom[3] = enc(1'b1, 2'b10, 4'd0, 4'd1, 4'd2, OP_SUB, ic);
        rom[4] = li(4'd0, 12'h5a5);                                // Dropped
        rom[5] = enc(1'b1, 2'b11, 4'd0, 4'd0, 4'd0, OP_OR, 12'd40);
        reset_core();
        wait_stores(3);
        check_store(0, '0, expect_result(1'b0, OP_SUB, sext(ia), sext(ib), ic));
        check_store(1, '0, expect_result(1'b1, OP_SUB, sext(ia), sext(ib), ic));
        check_store(2, 32'd40, '0);
    endtask

    task automatic follow_jumps();
        clear_rom();
        rom[0]  = enc(1'b1, 2'b00, 4'd15, 4'd0, 4'd0, OP_OR, 12'd10);
        rom[10] = enc(1'b1, 2'b10, 4'd0, 4'd15, 4'd0, OP_OR, 12'd0);
        rom[11] = enc(1'b1, 2'b00, 4'd15, 4'd15, 4'd0, OP_ADD, 12'd9);
        rom[20] = enc(1'b1, 2'b11, 4'd15, 4'd0, 4'd0, OP_OR, 12'd50);
        reset_core();
        @(negedge clk);
        check("o_insn_addr", 32'd10, o_insn_addr);
        wait_stores(2);
        check_store(0, '0, 32'd10);        // PC read of the store itself
        check_store(1, 32'd50, 32'd20);
    endtask

    task automatic load_under_backpressure();
        word_t preload [4];
        clear_rom();
        mem.delete();
        for (int k = 0; k < 4; k++) begin
            preload[k] = rand_bits(32);
            mem[word_t'(100 + k)] = preload[k];
            rom[k] = enc(1'b1, 2'b01, reg_idx_t'(k + 1), 4'd0, 4'd0, OP_OR, imm_t'(100 + k));
            rom[k + 4] = enc(1'b1, 2'b11, reg_idx_t'(k + 1), 4'd0, 4'd0, OP_OR,
                             imm_t'(200 + k));
        end
        withhold = 1'b1;
        reset_core();
        repeat (15) @(negedge clk);
        check("o_insn_addr", 32'd2, o_insn_addr);   // Third load out of credit
        check("o_req_valid", '0, word_t'(o_req_valid));
        @(posedge clk);
        withhold = 1'b0;
        wait_stores(4);
        for (int k = 0; k < 4; k++) begin
            check_store(k, word_t'(200 + k), preload[k]);
        end
    endtask

    task automatic halt_on_illegal();
        word_t forms [4];
        forms[0] = enc(1'b0, 2'b00, 4'd1, 4'd0, 4'd0, OP_RSVD, 12'd0);
        forms[1] = 32'hF000_0000;
        forms[2] = 32'h8123_4567;
        forms[3] = 32'hC000_2000;
        for (int f = 0; f < 4; f++) begin
            clear_rom();
            rom[0] = li(4'd1, 12'd5);
            rom[1] = forms[f];
            rom[2] = enc(1'b1, 2'b10, 4'd0, 4'd1, 4'd0, OP_OR, 12'd0);
            reset_core();
            @(negedge clk);
            check("o_insn_addr", 32'd1, o_insn_addr);   // Restarted from the reset vector
            check("o_halt", '0, word_t'(o_halt));
            repeat (8) begin
                @(negedge clk);
                check("o_halt", 32'd1, word_t'(o_halt));
                check("o_insn_addr", 32'd1, o_insn_addr);
                check("o_req_valid", '0, word_t'(o_req_valid));
            end
            @(posedge clk);
            check("store count", '0, word_t'(store_log.size()));
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        reset_left = 4;
        withhold = 1'b0;
        i_credit_return = 1'b0;
        i_rsp_valid = 1'b0;
        i_rsp_data = '0;
        cycles = 0;
        lfsr = SEED;
        clear_rom();
        sweep_alu_ops();
        swap_operand_types();
        follow_jumps();
        load_under_backpressure();
        halt_on_illegal();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/risc_core_assertions.sv */
`default_nettype none

module risc_core_assertions #(
    parameter int MEM_CREDITS = 2,
    parameter int CREDIT_W    = 2
) (
    input wire                clk,
    input wire                reset_n,
    input wire                o_req_valid,
    input wire                i_credit_return,
    input wire                o_halt,
    input wire [CREDIT_W-1:0] credits
);

    timeunit 1ns;
    timeprecision 100ps;

    int avail;   // Credits left, counted from the channel traffic

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            avail <= MEM_CREDITS;
        end else begin
            avail <= avail - (o_req_valid ? 1 : 0) + (i_credit_return ? 1 : 0);
        end
    end

    a_credit_used: assert property (@(posedge clk) disable iff (!reset_n)
        o_req_valid |-> (avail > 0))
        else $error("request issued with no credit left");

    a_quiet_halt: assert property (@(posedge clk) disable iff (!reset_n)
        o_halt |-> !o_req_valid)
        else $error("request issued while halted");

    // Halt holds until reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        o_halt |=> o_halt)
        else $error("halt dropped without reset");

    a_reset_state: assert property (@(posedge clk)
        !reset_n |=> (!o_halt && (credits == CREDIT_W'(MEM_CREDITS))))
        else $error("halt or credit count wrong after reset");

endmodule

`default_nettype wire

/* verilog/risc_core.sv */
`default_nettype none

module risc_core import core_pkg::*; #(
    parameter word_t RESET_VECTOR = '0,
    parameter int    MEM_CREDITS  = 2
) (
    input  wire        clk,
    input  wire        reset_n,
    output word_t      o_insn_addr,
    input  wire word_t i_insn_data,
    output logic       o_req_valid,
    output mem_req_t   o_req,
    input  wire        i_credit_return,
    input  wire        i_rsp_valid,
    input  wire word_t i_rsp_data,
    output logic       o_halt
);

    decoded_insn_t dec;
    word_t         x_value;
    word_t         y_value;
    word_t         z_value;
    word_t         result;
    word_t         pc;
    logic          wr_en;
    reg_idx_t      wr_idx;
    word_t         wr_data;

    assign o_insn_addr = pc;   // Fetch is always at the PC

    insn_decode u_decode (
        .i_insn (i_insn_data),
        .o_dec  (dec)
    );

    reg_file u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_x_idx   (dec.x_idx),
        .i_y_idx   (dec.y_idx),
        .i_z_idx   (dec.z_idx),
        .i_pc      (pc),
        .i_wr_en   (wr_en),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data),
        .o_x_value (x_value),
        .o_y_value (y_value),
        .o_z_value (z_value)
    );

    exec_unit u_exec (
        .i_dec     (dec),
        .i_x_value (x_value),
        .i_y_value (y_value),
        .o_result  (result)
    );

    core_control #(
        .RESET_VECTOR (RESET_VECTOR),
        .MEM_CREDITS  (MEM_CREDITS)
    ) u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_dec           (dec),
        .i_result        (result),
        .i_z_value       (z_value),
        .i_credit_return (i_credit_return),
        .i_rsp_valid     (i_rsp_valid),
        .i_rsp_data      (i_rsp_data),
        .o_pc            (pc),
        .o_wr_en         (wr_en),
        .o_wr_idx        (wr_idx),
        .o_wr_data       (wr_data),
        .o_req_valid     (o_req_valid),
        .o_req           (o_req),
        .o_halt          (o_halt)
    );

endmodule

`default_nettype wire

/* verilog/core_control.sv */
`default_nettype none

module core_control import core_pkg::*; #(
    parameter word_t RESET_VECTOR = '0,
    parameter int    MEM_CREDITS  = 2
) (
    input  wire                clk,
    input  wire                reset_n,
    input  wire decoded_insn_t i_dec,
    input  wire word_t         i_result,
    input  wire word_t         i_z_value,
    input  wire                i_credit_return,
    input  wire                i_rsp_valid,
    input  wire word_t         i_rsp_data,
    output word_t              o_pc,
    output logic               o_wr_en,
    output reg_idx_t           o_wr_idx,
    output word_t              o_wr_data,
    output logic               o_req_valid,
    output mem_req_t           o_req,
    output logic               o_halt
);

    localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);

    ctrl_state_t         state_q;
    ctrl_state_t         state_d;
    word_t               pc_q;
    word_t               pc_d;
    word_t               pc_seq;
    logic [CREDIT_W-1:0] credits_q;
    reg_idx_t            load_idx_q;   // Destination of the pending load
    logic                executing;
    logic                is_mem;
    logic                is_load;
    logic                has_credit;
    logic                load_done;

    // True for R1..R14, the indices with real storage
    function automatic logic is_gpr(reg_idx_t idx);
        return (idx != '0) && (idx != PC_INDEX);
    endfunction

    assign executing  = (state_q == ST_RUN) && !i_dec.illegal;
    assign is_mem     = (i_dec.deref != 2'b00);
    assign is_load    = (i_dec.deref == 2'b01);
    assign has_credit = (credits_q != '0);
    assign load_done  = (state_q == ST_LOAD_WAIT) && i_rsp_valid;
    assign pc_seq     = pc_q + 32'd1;

    // Mode 10 stores to address Z, modes 01 and 11 address by the result
    assign o_req_valid = executing && is_mem && has_credit;
    assign o_req.write = i_dec.deref[1];
    assign o_req.addr  = i_dec.deref[0] ? i_result : i_z_value;
    assign o_req.data  = i_dec.deref[0] ? i_z_value : i_result;

    // Single write port, ALU result or load data
    always_comb begin
        if (state_q == ST_LOAD_WAIT) begin
            o_wr_en   = i_rsp_valid && is_gpr(load_idx_q);
            o_wr_idx  = load_idx_q;
            o_wr_data = i_rsp_data;
        end else begin
            o_wr_en   = executing && !is_mem && is_gpr(i_dec.z_idx);
            o_wr_idx  = i_dec.z_idx;
            o_wr_data = i_result;
        end
    end

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            ST_RUN: begin
                if (i_dec.illegal) begin
                    state_d = ST_HALTED;                   // PC stays on the bad word
                end else if (!is_mem) begin
                    pc_d = (i_dec.z_idx == PC_INDEX) ? i_result : pc_seq;
                end else if (has_credit) begin
                    if (is_load) begin
                        state_d = ST_LOAD_WAIT;
                    end else begin
                        pc_d = pc_seq;                     // Store done on issue
                    end
                end
            end
            ST_LOAD_WAIT: begin
                if (load_done) begin
                    state_d = ST_RUN;
                    pc_d    = (load_idx_q == PC_INDEX) ? i_rsp_data : pc_seq;
                end
            end
            default: begin
                state_d = ST_HALTED;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q   <= ST_RUN;
            pc_q      <= RESET_VECTOR;
            credits_q <= CREDIT_W'(MEM_CREDITS);
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            case ({o_req_valid, i_credit_return})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_req_valid && is_load) begin
            load_idx_q <= i_dec.z_idx;
        end
    end

    assign o_pc   = pc_q;
    assign o_halt = (state_q == ST_HALTED);

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`default_nettype none

module exec_unit import core_pkg::*; (
    input  wire decoded_insn_t i_dec,
    input  wire word_t         i_x_value,
    input  wire word_t         i_y_value,
    output word_t              o_result
);

    word_t imm_ext;
    word_t opnd_o;
    word_t addend;
    word_t op_out;
    logic  shift_ovf;
    logic  cmp_le;
    logic  cmp_eq;

    assign imm_ext = {{20{i_dec.imm[11]}}, i_dec.imm};

    // Type bit swaps the roles of Y and I
    assign opnd_o = i_dec.insn_type ? imm_ext : i_y_value;
    assign addend = i_dec.insn_type ? i_y_value : imm_ext;

    assign shift_ovf = |opnd_o[31:5];  // Shift of 32 or more
    assign cmp_le    = $signed(i_x_value) <= $signed(opnd_o);
    assign cmp_eq    = i_x_value == opnd_o;

    always_comb begin
        case (i_dec.op)
            OP_OR:   op_out = i_x_value | opnd_o;
            OP_AND:  op_out = i_x_value & opnd_o;
            OP_ADD:  op_out = i_x_value + opnd_o;
            OP_MUL:  op_out = i_x_value * opnd_o;     // Low half only
            OP_SHL:  op_out = shift_ovf ? '0 : i_x_value << opnd_o[4:0];
            OP_LE:   op_out = {31'b0, cmp_le};
            OP_EQ:   op_out = {31'b0, cmp_eq};
            OP_NOR:  op_out = ~(i_x_value | opnd_o);
            OP_NAND: op_out = ~(i_x_value & opnd_o);
            OP_XOR:  op_out = i_x_value ^ opnd_o;
            OP_SUB:  op_out = i_x_value - opnd_o;
            OP_XORN: op_out = i_x_value ^ ~opnd_o;
            OP_SHR:  op_out = shift_ovf ? '0 : i_x_value >> opnd_o[4:0];
            OP_GT:   op_out = {31'b0, ~cmp_le};
            OP_NE:   op_out = {31'b0, ~cmp_eq};
            default: op_out = '0;                      // Reserved code
        endcase
    end

    // Addend goes on after the operation
    assign o_result = op_out + addend;

endmodule

`default_nettype wire

/* verilog/insn_decode.sv */
`default_nettype none

module insn_decode import core_pkg::*; (
    input  wire word_t    i_insn,
    output decoded_insn_t o_dec
);

    logic top_bit_set;
    logic reserved_op;

    // Field layout
    //   31    must be zero
    //   30    type
    //   29:28 dereference mode
    //   27:24 Z, 23:20 X, 19:16 Y
    //   15:12 operation
    //   11:0  signed immediate
    always_comb begin
        o_dec.insn_type = i_insn[30];
        o_dec.deref     = i_insn[29:28];
        o_dec.z_idx     = i_insn[27:24];
        o_dec.x_idx     = i_insn[23:20];
        o_dec.y_idx     = i_insn[19:16];
        o_dec.op        = i_insn[15:12];
        o_dec.imm       = i_insn[11:0];
        o_dec.illegal   = top_bit_set | reserved_op;
    end

    assign top_bit_set = i_insn[31];                 // Covers the 1111 nibble too
    assign reserved_op = (i_insn[15:12] == OP_RSVD);

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire           clk,
    input  wire           reset_n,
    input  wire reg_idx_t i_x_idx,
    input  wire reg_idx_t i_y_idx,
    input  wire reg_idx_t i_z_idx,
    input  wire word_t    i_pc,
    input  wire           i_wr_en,
    input  wire reg_idx_t i_wr_idx,
    input  wire word_t    i_wr_data,
    output word_t         o_x_value,
    output word_t         o_y_value,
    output word_t         o_z_value
);

    // Only R1..R14 have storage
    word_t gpr [1:14];

    // R0 is hard zero, R15 maps onto the PC
    function automatic word_t read_reg(reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (idx == PC_INDEX) begin
            value = i_pc;
        end else begin
            value = gpr[idx];
        end
        return value;
    endfunction

    assign o_x_value = read_reg(i_x_idx);
    assign o_y_value = read_reg(i_y_idx);
    assign o_z_value = read_reg(i_z_idx);

    // Index range is checked by the controller
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                gpr[i] <= '0;
            end
        end else if (i_wr_en) begin
            gpr[i_wr_idx] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;    // Data and address word
    typedef logic [3:0]  reg_idx_t;
    typedef logic [11:0] imm_t;     // Raw immediate, signed
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  deref_t;

    localparam reg_idx_t PC_INDEX = 4'd15;

    // Operation codes
    localparam alu_op_t OP_OR   = 4'd0;
    localparam alu_op_t OP_AND  = 4'd1;
    localparam alu_op_t OP_ADD  = 4'd2;
    localparam alu_op_t OP_MUL  = 4'd3;
    localparam alu_op_t OP_RSVD = 4'd4;  // Reserved, illegal
    localparam alu_op_t OP_SHL  = 4'd5;
    localparam alu_op_t OP_LE   = 4'd6;
    localparam alu_op_t OP_EQ   = 4'd7;
    localparam alu_op_t OP_NOR  = 4'd8;
    localparam alu_op_t OP_NAND = 4'd9;
    localparam alu_op_t OP_XOR  = 4'd10;
    localparam alu_op_t OP_SUB  = 4'd11;
    localparam alu_op_t OP_XORN = 4'd12;
    localparam alu_op_t OP_SHR  = 4'd13;
    localparam alu_op_t OP_GT   = 4'd14;
    localparam alu_op_t OP_NE   = 4'd15;

    typedef struct packed {
        logic     insn_type;  // 0 means O=Y, A=I
        deref_t   deref;
        reg_idx_t z_idx;
        reg_idx_t x_idx;
        reg_idx_t y_idx;
        alu_op_t  op;
        imm_t     imm;
        logic     illegal;
    } decoded_insn_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t data;
    } mem_req_t;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_LOAD_WAIT,
        ST_HALTED
    } ctrl_state_t;

endpackage

`default_nettype wire
